// File: mem_stimulus.txt
# name aluop addr reg2 flags bus_rdata exp_wdata exp_sel exp_wrdata exp_we exp_exc
# every field after the name is hex, exp_sel is the expected bus byte select
lb_off0   e0 00001000 00000000 00000000 80f17f82 ffffff82 1 00000000 0 00000000
lb_off1   e0 00001001 00000000 00000000 80f17f82 0000007f 2 00000000 0 00000000
lb_off2   e0 00001002 00000000 00000000 80f17f82 fffffff1 4 00000000 0 00000000
lb_off3   e0 00001003 00000000 00000000 80f17f82 ffffff80 8 00000000 0 00000000
lbu_off0  e4 00001000 00000000 00000000 80f17f82 00000082 1 00000000 0 00000000
lbu_off1  e4 00001001 00000000 00000000 80f17f82 0000007f 2 00000000 0 00000000
lbu_off2  e4 00001002 00000000 00000000 80f17f82 000000f1 4 00000000 0 00000000
lbu_off3  e4 00001003 00000000 00000000 80f17f82 00000080 8 00000000 0 00000000
lh_off0   e1 00001000 00000000 00000000 80f17f82 00007f82 3 00000000 0 00000000
lh_off2   e1 00001002 00000000 00000000 80f17f82 ffff80f1 c 00000000 0 00000000
lhu_off0  e5 00001000 00000000 00000000 80f17f82 00007f82 3 00000000 0 00000000
lhu_off2  e5 00001002 00000000 00000000 80f17f82 000080f1 c 00000000 0 00000000
lw_word   e3 00001000 00000000 00000000 80f17f82 80f17f82 f 00000000 0 00000000
sb_off0   e8 00001100 a5c396e4 00000000 00000000 00000000 1 e4e4e4e4 1 00000000
sb_off1   e8 00001101 a5c396e4 00000000 00000000 00000000 2 e4e4e4e4 1 00000000
sb_off2   e8 00001102 a5c396e4 00000000 00000000 00000000 4 e4e4e4e4 1 00000000
sb_off3   e8 00001103 a5c396e4 00000000 00000000 00000000 8 e4e4e4e4 1 00000000
sh_off0   e9 00001100 a5c396e4 00000000 00000000 00000000 3 96e496e4 1 00000000
sh_off2   e9 00001102 a5c396e4 00000000 00000000 00000000 c 96e496e4 1 00000000
sw_word   eb 00001100 a5c396e4 00000000 00000000 00000000 f a5c396e4 1 00000000
ll_load   f0 00002000 00000000 00000000 13572468 13572468 f 00000000 0 00000000
sc_pass   f8 00002000 0badcafe 00000000 00000000 00000001 f 0badcafe 1 00000000
sc_fail   f8 00002000 0badcafe 00000000 00000000 00000000 0 00000000 0 00000000
exc_sys   eb 00003000 11111111 00000900 00000000 00000000 0 00000000 0 00000008
exc_adel  e1 00003001 00000000 00004000 00000000 00000000 0 00000000 0 00000004
exc_brk   e3 00003004 00000000 00002400 00000000 00000000 0 00000000 0 00000009
exc_eret  00 00003008 00000000 00001000 00000000 00000000 0 00000000 0 0000000e

// File: verilog.f
mem_pkg.sv
load_align.sv
store_align.sv
ll_link.sv
except_resolve.sv
mem_req_ctrl.sv
mem_stage.sv
tb_mem_stage.sv

// File: Makefile
# Verilator build and run of the memory stage testbench
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mem_stage.sv
// self-checking testbench for the memory stage, replays mem_stimulus.txt against a small bus model
`timescale 1ns/1ns

module tb_mem_stage;

    localparam int CYCLES_PER_TEST = 20;
    localparam int RESET_CYCLES    = 10;

    localparam logic [2:0] BUS_IDLE  = 3'd0;
    localparam logic [2:0] BUS_ADDR  = 3'd1;
    localparam logic [2:0] BUS_READ  = 3'd2;
    localparam logic [2:0] BUS_DATA  = 3'd3;
    localparam logic [2:0] BUS_WRITE = 3'd4;
    localparam logic [2:0] BUS_WDONE = 3'd5;

    logic                clk               = 1'b0;
    logic                rst_i             = 1'b1;
    mem_pkg::aluop_t     aluop_i           = mem_pkg::OP_NOP;
    mem_pkg::word_t      mem_addr_i        = '0;
    mem_pkg::word_t      reg2_i            = '0;
    mem_pkg::exc_flags_t excepttype_i      = '0;
    mem_pkg::word_t      mem_data_i        = '0;
    logic                mem_data_valid_i  = 1'b0;
    logic                mem_addr_ready_i  = 1'b0;
    logic                mem_write_ready_i = 1'b0;

    mem_pkg::word_t wdata_o;
    mem_pkg::word_t excepttype_o;
    mem_pkg::word_t mem_addr_o;
    mem_pkg::word_t mem_data_o;
    mem_pkg::sel_t  mem_sel_o;
    logic           mem_ce_o;
    logic           mem_we_o;
    logic           mem_re_o;
    logic           stall_o;

    // one entry per stimulus line
    string           t_name[$];
    mem_pkg::aluop_t t_op[$];
    mem_pkg::word_t  t_addr[$];
    mem_pkg::word_t  t_reg2[$];
    mem_pkg::word_t  t_flags[$];
    mem_pkg::word_t  t_rdata[$];
    mem_pkg::word_t  t_wdata[$];
    mem_pkg::sel_t   t_sel[$];
    mem_pkg::word_t  t_wrdata[$];
    logic            t_we[$];
    mem_pkg::word_t  t_exc[$];

    mem_pkg::word_t bus_word = '0;
    logic [2:0]     bus_state;
    logic [1:0]     bus_delay;
    logic [31:0]    rng_state;
    logic           addr_seen = 1'b0;
    int             cycle_count = 0;
    int             timeout_limit = 0;

    mem_stage mem_stage_i (
        .clk               (clk),
        .rst_i             (rst_i),
        .aluop_i           (aluop_i),
        .mem_addr_i        (mem_addr_i),
        .reg2_i            (reg2_i),
        .excepttype_i      (excepttype_i),
        .mem_data_i        (mem_data_i),
        .mem_data_valid_i  (mem_data_valid_i),
        .mem_addr_ready_i  (mem_addr_ready_i),
        .mem_write_ready_i (mem_write_ready_i),
        .wdata_o           (wdata_o),
        .excepttype_o      (excepttype_o),
        .mem_addr_o        (mem_addr_o),
        .mem_data_o        (mem_data_o),
        .mem_sel_o         (mem_sel_o),
        .mem_ce_o          (mem_ce_o),
        .mem_we_o          (mem_we_o),
        .mem_re_o          (mem_re_o),
        .stall_o           (stall_o)
    );

    initial
    begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual)
        else report_failure($sformatf("Mismatch in test %s: %s expected %h actual %h",
                                      name, what, expected, actual));
    endtask

    // bus model: address ack one cycle after the request, data or write ack after a random delay
    always @(posedge clk)
    begin
        if (rst_i)
        begin
            bus_state         <= BUS_IDLE;
            bus_delay         <= 2'd0;
            rng_state         <= 32'd3523;
            mem_addr_ready_i  <= 1'b0;
            mem_data_valid_i  <= 1'b0;
            mem_write_ready_i <= 1'b0;
            mem_data_i        <= '0;
        end
        else
        begin
            case (bus_state)
                BUS_IDLE:
                begin
                    if (mem_re_o)
                    begin
                        mem_addr_ready_i <= 1'b1;
                        bus_state        <= BUS_ADDR;
                    end
                    else if (mem_we_o)
                    begin
                        bus_delay <= rng_state[17:16];
                        rng_state <= lcg_next(rng_state);
                        bus_state <= BUS_WRITE;
                    end
                end
                BUS_ADDR:
                begin
                    mem_addr_ready_i <= 1'b0;
                    bus_delay        <= rng_state[17:16];
                    rng_state        <= lcg_next(rng_state);
                    bus_state        <= BUS_READ;
                end
                BUS_READ:
                begin
                    if (bus_delay == 2'd0)
                    begin
                        mem_data_valid_i <= 1'b1;
                        mem_data_i       <= bus_word;
                        bus_state        <= BUS_DATA;
                    end
                    else
                    begin
                        bus_delay <= bus_delay - 2'd1;
                    end
                end
                BUS_DATA:
                begin
                    mem_data_valid_i <= 1'b0;
                    mem_data_i       <= '0;
                    bus_state        <= BUS_IDLE;
                end
                BUS_WRITE:
                begin
                    if (bus_delay == 2'd0)
                    begin
                        mem_write_ready_i <= 1'b1;
                        bus_state         <= BUS_WDONE;
                    end
                    else
                    begin
                        bus_delay <= bus_delay - 2'd1;
                    end
                end
                default:
                begin
                    mem_write_ready_i <= 1'b0;
                    bus_state         <= BUS_IDLE;
                end
            endcase
        end
    end

    // read protocol: no new request between address ack and data, stall held meanwhile
    always @(negedge clk)
    begin
        if (!rst_i)
        begin
            if (addr_seen)
                assert (!mem_re_o)
                else report_failure("mem_re_o raised again before the read data arrived");
            if ((mem_re_o || addr_seen) && !mem_data_valid_i)
                assert (stall_o)
                else report_failure("stall_o low while a read is still outstanding");
            if (mem_data_valid_i)
                addr_seen <= 1'b0;
            else if (mem_addr_ready_i && mem_re_o)
                addr_seen <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit)
            report_failure($sformatf("run did not finish within %0d cycles", timeout_limit));
    end

    initial
    begin
        int              fd;
        int              fields;
        string           line;
        string           f_name;
        mem_pkg::aluop_t f_op;
        mem_pkg::word_t  f_addr;
        mem_pkg::word_t  f_reg2;
        mem_pkg::word_t  f_flags;
        mem_pkg::word_t  f_rdata;
        mem_pkg::word_t  f_wdata;
        mem_pkg::sel_t   f_sel;
        mem_pkg::word_t  f_wrdata;
        logic            f_we;
        mem_pkg::word_t  f_exc;
        logic            saw_we;
        logic            done;

        fd = $fopen("mem_stimulus.txt", "r");
        assert (fd != 0)
        else report_failure("cannot open the stimulus file mem_stimulus.txt");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", f_name, f_op, f_addr,
                             f_reg2, f_flags, f_rdata, f_wdata, f_sel, f_wrdata, f_we, f_exc);
            assert (fields == 11)
            else report_failure($sformatf("stimulus line is malformed: %s", line));
            t_name.push_back(f_name);
            t_op.push_back(f_op);
            t_addr.push_back(f_addr);
            t_reg2.push_back(f_reg2);
            t_flags.push_back(f_flags);
            t_rdata.push_back(f_rdata);
            t_wdata.push_back(f_wdata);
            t_sel.push_back(f_sel);
            t_wrdata.push_back(f_wrdata);
            t_we.push_back(f_we);
            t_exc.push_back(f_exc);
        end
        $fclose(fd);
        timeout_limit = RESET_CYCLES + 2 + CYCLES_PER_TEST * t_op.size();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        assert (!mem_re_o && !mem_we_o && !mem_ce_o && !stall_o)
        else report_failure("bus strobes or stall not low after reset");

        for (int i = 0; i < t_op.size(); i++)
        begin
            @(posedge clk);
            aluop_i      <= t_op[i];
            mem_addr_i   <= t_addr[i];
            reg2_i       <= t_reg2[i];
            excepttype_i <= t_flags[i];
            bus_word     <= t_rdata[i];
            saw_we = 1'b0;
            done   = 1'b0;
            while (!done)
            begin
                @(negedge clk);
                check_value(t_name[i], "excepttype_o", t_exc[i], excepttype_o);
                if (t_exc[i] != 32'd0)
                    assert (!mem_we_o && !mem_re_o)
                    else report_failure($sformatf("bus access under exception in test %s",
                                                  t_name[i]));
                // bus enabled exactly when the line expects byte lanes
                check_value(t_name[i], "mem_ce_o", 32'(t_sel[i] != 4'h0), 32'(mem_ce_o));
                check_value(t_name[i], "mem_sel_o", 32'(t_sel[i]), 32'(mem_sel_o));
                if (mem_we_o)
                begin
                    saw_we = 1'b1;
                    check_value(t_name[i], "mem_data_o", t_wrdata[i], mem_data_o);
                    check_value(t_name[i], "mem_addr_o", t_addr[i], mem_addr_o);
                end
                // access ends in the cycle the stall drops
                if (!stall_o)
                begin
                    check_value(t_name[i], "wdata_o", t_wdata[i], wdata_o);
                    check_value(t_name[i], "write seen", 32'(t_we[i]), 32'(saw_we));
                    done = 1'b1;
                end
            end
        end

        @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: mem_stage.sv
// memory-access stage top level, connects the align, link, exception and bus control blocks
`timescale 1ns/1ns

module mem_stage (
    input  logic                clk,
    input  logic                rst_i,

    // from execute
    input  mem_pkg::aluop_t     aluop_i,
    input  mem_pkg::word_t      mem_addr_i,
    input  mem_pkg::word_t      reg2_i,
    input  mem_pkg::exc_flags_t excepttype_i,

    // data bus responses
    input  mem_pkg::word_t      mem_data_i,
    input  logic                mem_data_valid_i,
    input  logic                mem_addr_ready_i,
    input  logic                mem_write_ready_i,

    // to write-back
    output mem_pkg::word_t      wdata_o,
    output mem_pkg::word_t      excepttype_o,

    // data bus requests
    output mem_pkg::word_t      mem_addr_o,
    output mem_pkg::word_t      mem_data_o,
    output mem_pkg::sel_t       mem_sel_o,
    output logic                mem_ce_o,
    output logic                mem_we_o,
    output logic                mem_re_o,

    output logic                stall_o
);

    mem_pkg::sel_t      load_sel;
    logic               load_ce;
    mem_pkg::sel_t      store_sel;
    logic               store_ce;
    mem_pkg::mem_word_t store_data;
    logic               sc_pass;
    mem_pkg::word_t     exc_code;
    logic               exc_taken;
    logic               advance;

    assign mem_addr_o   = mem_addr_i;
    assign mem_data_o   = store_data;
    assign excepttype_o = exc_code;

    load_align load_align_i (
        .aluop_i    (aluop_i),
        .addr_lo_i  (mem_addr_i[1:0]),
        .mem_data_i (mem_data_i),
        .sc_pass_i  (sc_pass),
        .wdata_o    (wdata_o),
        .load_sel_o (load_sel),
        .load_ce_o  (load_ce)
    );

    store_align store_align_i (
        .aluop_i      (aluop_i),
        .addr_lo_i    (mem_addr_i[1:0]),
        .reg2_i       (reg2_i),
        .sc_pass_i    (sc_pass),
        .store_data_o (store_data),
        .store_sel_o  (store_sel),
        .store_ce_o   (store_ce)
    );

    ll_link ll_link_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .aluop_i     (aluop_i),
        .advance_i   (advance),
        .exc_taken_i (exc_taken),
        .sc_pass_o   (sc_pass)
    );

    except_resolve except_resolve_i (
        .excepttype_i (excepttype_i),
        .exc_code_o   (exc_code),
        .exc_taken_o  (exc_taken)
    );

    mem_req_ctrl mem_req_ctrl_i (
        .clk               (clk),
        .rst_i             (rst_i),
        .load_ce_i         (load_ce),
        .load_sel_i        (load_sel),
        .store_ce_i        (store_ce),
        .store_sel_i       (store_sel),
        .exc_taken_i       (exc_taken),
        .mem_addr_ready_i  (mem_addr_ready_i),
        .mem_data_valid_i  (mem_data_valid_i),
        .mem_write_ready_i (mem_write_ready_i),
        .mem_ce_o          (mem_ce_o),
        .mem_we_o          (mem_we_o),
        .mem_re_o          (mem_re_o),
        .mem_sel_o         (mem_sel_o),
        .stall_o           (stall_o),
        .advance_o         (advance)
    );

    // odd halfword address must come with an address error from execute
    a_half_aligned: assert property (@(posedge clk) disable iff (rst_i)
        ((aluop_i == mem_pkg::OP_LH || aluop_i == mem_pkg::OP_LHU) && mem_addr_i[0])
        |-> excepttype_i[mem_pkg::ADEL_IDX])
        else $error("misaligned halfword load without address error");

endmodule

// File: mem_req_ctrl.sv
// data bus strobes, read request filter and memory stall request
`timescale 1ns/1ns

module mem_req_ctrl (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          load_ce_i,
    input  mem_pkg::sel_t load_sel_i,
    input  logic          store_ce_i,
    input  mem_pkg::sel_t store_sel_i,
    input  logic          exc_taken_i,
    input  logic          mem_addr_ready_i,
    input  logic          mem_data_valid_i,
    input  logic          mem_write_ready_i,
    output logic          mem_ce_o,
    output logic          mem_we_o,
    output logic          mem_re_o,
    output mem_pkg::sel_t mem_sel_o,
    output logic          stall_o,
    output logic          advance_o
);

    logic load_ok;
    logic store_ok;
    logic addr_taken_q;

    // an exception kills the access before it reaches the bus
    assign load_ok  = load_ce_i & ~exc_taken_i;
    assign store_ok = store_ce_i & ~exc_taken_i;

    assign mem_ce_o  = load_ok | store_ok;
    assign mem_we_o  = store_ok;
    assign mem_sel_o = store_ok ? store_sel_i : (load_ok ? load_sel_i : 4'b0000);

    // read request drops once the bus has latched the address
    assign mem_re_o = load_ok & ~addr_taken_q;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            addr_taken_q <= 1'b0;
        end
        else if (mem_data_valid_i)
        begin
            // data back, ready for the next read
            addr_taken_q <= 1'b0;
        end
        else if (mem_addr_ready_i && mem_re_o)
        begin
            addr_taken_q <= 1'b1;
        end
    end

    assign stall_o   = (store_ok & ~mem_write_ready_i) | (load_ok & ~mem_data_valid_i);
    assign advance_o = ~stall_o;

    a_we_re_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(mem_we_o && mem_re_o))
        else $error("read and write strobes high together");

    a_sel_on_ce: assert property (@(posedge clk) disable iff (rst_i)
        mem_ce_o |-> (mem_sel_o != 4'b0000))
        else $error("bus enabled with no byte lane selected");

endmodule

// File: except_resolve.sv
// fixed-priority selection of the final exception code from the execute flags
`timescale 1ns/1ns

module except_resolve (
    input  mem_pkg::exc_flags_t excepttype_i,
    output mem_pkg::word_t      exc_code_o,
    output logic                exc_taken_o
);

    always_comb
    begin
        exc_code_o = mem_pkg::EXC_NONE;
        if (excepttype_i[mem_pkg::SYSCALL_IDX])
        begin
            exc_code_o = mem_pkg::EXC_SYSCALL;
        end
        else if (excepttype_i[mem_pkg::BREAK_IDX])
        begin
            exc_code_o = mem_pkg::EXC_BREAK;
        end
        else if (excepttype_i[mem_pkg::INSTINVALID_IDX])
        begin
            exc_code_o = mem_pkg::EXC_INSTINVALID;
        end
        else if (excepttype_i[mem_pkg::TRAP_IDX])
        begin
            exc_code_o = mem_pkg::EXC_TRAP;
        end
        else if (excepttype_i[mem_pkg::OVERFLOW_IDX])
        begin
            exc_code_o = mem_pkg::EXC_OVERFLOW;
        end
        else if (excepttype_i[mem_pkg::ADEL_IDX])
        begin
            exc_code_o = mem_pkg::EXC_ADEL;
        end
        else if (excepttype_i[mem_pkg::ADES_IDX])
        begin
            exc_code_o = mem_pkg::EXC_ADES;
        end
        else if (excepttype_i[mem_pkg::ERET_IDX])
        begin
            // eret is handled as an exception by the CP0 logic
            exc_code_o = mem_pkg::EXC_ERET;
        end
    end

    assign exc_taken_o = (exc_code_o != mem_pkg::EXC_NONE);

endmodule

// File: ll_link.sv
// link bit for the load-linked / store-conditional pair
`timescale 1ns/1ns

module ll_link (
    input  logic            clk,
    input  logic            rst_i,
    input  mem_pkg::aluop_t aluop_i,
    input  logic            advance_i,
    input  logic            exc_taken_i,
    output logic            sc_pass_o
);

    logic link_q;

    // only moves on the edge that retires the instruction
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            link_q <= 1'b0;
        end
        else if (advance_i)
        begin
            if ((aluop_i == mem_pkg::OP_LL) && !exc_taken_i)
            begin
                link_q <= 1'b1;
            end
            else if (aluop_i == mem_pkg::OP_SC)
            begin
                // any sc consumes the link, pass or fail
                link_q <= 1'b0;
            end
        end
    end

    assign sc_pass_o = (aluop_i == mem_pkg::OP_SC) && link_q;

endmodule

// File: store_align.sv
// store data replication into byte lanes and store byte selects
`timescale 1ns/1ns

module store_align (
    input  mem_pkg::aluop_t    aluop_i,
    input  logic [1:0]         addr_lo_i,
    input  mem_pkg::word_t     reg2_i,
    input  logic               sc_pass_i,
    output mem_pkg::mem_word_t store_data_o,
    output mem_pkg::sel_t      store_sel_o,
    output logic               store_ce_o
);

    always_comb
    begin
        store_data_o = '0;
        store_sel_o  = 4'b0000;
        store_ce_o   = 1'b0;
        case (aluop_i)
            mem_pkg::OP_SB:
            begin
                // same byte on every lane, select picks one
                store_data_o.b = {4{reg2_i[7:0]}};
                store_sel_o    = mem_pkg::sel_t'(4'b0001 << addr_lo_i);
                store_ce_o     = 1'b1;
            end
            mem_pkg::OP_SH:
            begin
                store_data_o.h = {2{reg2_i[15:0]}};
                store_sel_o    = addr_lo_i[1] ? 4'b1100 : 4'b0011;
                store_ce_o     = 1'b1;
            end
            mem_pkg::OP_SW:
            begin
                store_data_o = reg2_i;
                store_sel_o  = 4'b1111;
                store_ce_o   = 1'b1;
            end
            mem_pkg::OP_SC:
            begin
                // failed sc leaves memory alone
                if (sc_pass_i)
                begin
                    store_data_o = reg2_i;
                    store_sel_o  = 4'b1111;
                    store_ce_o   = 1'b1;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: load_align.sv
// load lane steering and extension, plus load byte selects and the write-back value
`timescale 1ns/1ns

module load_align (
    input  mem_pkg::aluop_t    aluop_i,
    input  logic [1:0]         addr_lo_i,
    input  mem_pkg::mem_word_t mem_data_i,
    input  logic               sc_pass_i,
    output mem_pkg::word_t     wdata_o,
    output mem_pkg::sel_t      load_sel_o,
    output logic               load_ce_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    mem_pkg::sel_t byte_sel;
    mem_pkg::sel_t half_sel;

    // lane picks, halfword uses only address bit 1
    assign byte_lane = mem_data_i.b[addr_lo_i];
    assign half_lane = mem_data_i.h[addr_lo_i[1]];
    assign byte_sel  = mem_pkg::sel_t'(4'b0001 << addr_lo_i);
    assign half_sel  = addr_lo_i[1] ? 4'b1100 : 4'b0011;

    always_comb
    begin
        wdata_o    = '0;
        load_sel_o = 4'b0000;
        load_ce_o  = 1'b0;
        case (aluop_i)
            mem_pkg::OP_LB,
            mem_pkg::OP_LBU:
            begin
                wdata_o    = {{24{byte_lane[7] & (aluop_i == mem_pkg::OP_LB)}}, byte_lane};
                load_sel_o = byte_sel;
                load_ce_o  = 1'b1;
            end
            mem_pkg::OP_LH,
            mem_pkg::OP_LHU:
            begin
                wdata_o    = {{16{half_lane[15] & (aluop_i == mem_pkg::OP_LH)}}, half_lane};
                load_sel_o = half_sel;
                load_ce_o  = 1'b1;
            end
            mem_pkg::OP_LW,
            mem_pkg::OP_LL:
            begin
                wdata_o    = mem_data_i;
                load_sel_o = 4'b1111;
                load_ce_o  = 1'b1;
            end
            mem_pkg::OP_SC:
            begin
                // success flag goes back to rt
                wdata_o = {31'd0, sc_pass_i};
            end
            default:
            begin
            end
        endcase
    end

endmodule

// File: mem_pkg.sv
// shared types, operation codes and exception encodings for the memory stage, use by scoped name
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [31:0] exc_flags_t;

    // one bus word, read by byte lane or by halfword lane
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_t;

    // memory operation codes from execute
    localparam aluop_t OP_NOP = 8'b0000_0000;
    localparam aluop_t OP_LB  = 8'b1110_0000;
    localparam aluop_t OP_LH  = 8'b1110_0001;
    localparam aluop_t OP_LW  = 8'b1110_0011;
    localparam aluop_t OP_LBU = 8'b1110_0100;
    localparam aluop_t OP_LHU = 8'b1110_0101;
    localparam aluop_t OP_SB  = 8'b1110_1000;
    localparam aluop_t OP_SH  = 8'b1110_1001;
    localparam aluop_t OP_SW  = 8'b1110_1011;
    localparam aluop_t OP_LL  = 8'b1111_0000;
    localparam aluop_t OP_SC  = 8'b1111_1000;

    // bit positions in the execute exception flags
    localparam int SYSCALL_IDX     = 8;
    localparam int INSTINVALID_IDX = 9;
    localparam int TRAP_IDX        = 10;
    localparam int OVERFLOW_IDX    = 11;
    localparam int ERET_IDX        = 12;
    localparam int BREAK_IDX       = 13;
    localparam int ADEL_IDX        = 14;
    localparam int ADES_IDX        = 15;

    // final codes, as written to Cause.ExcCode
    localparam word_t EXC_NONE        = 32'h0000_0000;
    localparam word_t EXC_ADEL        = 32'h0000_0004;
    localparam word_t EXC_ADES        = 32'h0000_0005;
    localparam word_t EXC_SYSCALL     = 32'h0000_0008;
    localparam word_t EXC_BREAK       = 32'h0000_0009;
    localparam word_t EXC_INSTINVALID = 32'h0000_000a;
    localparam word_t EXC_OVERFLOW    = 32'h0000_000c;
    localparam word_t EXC_TRAP        = 32'h0000_000d;
    localparam word_t EXC_ERET        = 32'h0000_000e;

endpackage
